/* logic/router_pkg.sv */
package router_pkg;

    ////////////////////////////////////////
    // widths

    localparam int NODE_ID_W = 4;
    localparam int NUM_NODES = 2 ** NODE_ID_W;
    localparam int PAYLOAD_W = 16;

    typedef logic [NODE_ID_W-1:0] node_id_t;

    // root always owns id 0
    localparam node_id_t ROOT_ID = '0;

    ////////////////////////////////////////
    // flit format

    typedef enum logic [1:0] {
        DATA      = 2'd0,
        ASSIGN_ID = 2'd1,
        ROUTE_ADD = 2'd2
    } flit_kind_e;

    typedef struct packed {
        flit_kind_e             kind;
        node_id_t               destination;
        node_id_t               source;
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    ////////////////////////////////////////
    // node state

    typedef enum logic [1:0] {
        JOIN_WAIT   = 2'd0,
        NORMAL      = 2'd1,
        FATAL_ERROR = 2'd2
    } routing_state_e;

endpackage

/* logic/flit_stage_if.sv */
`timescale 1ns/1ps

interface flit_stage_if;

    logic                   valid;
    router_pkg::flit_t      flit;
    logic                   deliver_local;
    logic                   route_hit;
    router_pkg::node_id_t   next_hop;
    // output register can take a flit this cycle
    logic                   advance;

    modport source (
        output valid, flit, deliver_local, route_hit, next_hop,
        input  advance
    );

    modport sink (
        input  valid, flit, deliver_local, route_hit, next_hop,
        output advance
    );

endinterface

/* logic/join_controller.sv */
`timescale 1ns/1ps

module join_controller #(
    parameter bit IS_ROOT = 1'b0
) (
    input  logic                       nocclk,
    input  logic                       rst_n,
    input  logic                       assign_valid,
    input  router_pkg::node_id_t       assign_id,
    output router_pkg::routing_state_e routing_state,
    output router_pkg::node_id_t       this_node_id
);

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            routing_state <= IS_ROOT ? router_pkg::NORMAL : router_pkg::JOIN_WAIT;
            this_node_id  <= router_pkg::ROOT_ID;
        end else begin
            case (routing_state)
                router_pkg::JOIN_WAIT: begin
                    if (assign_valid) begin
                        this_node_id  <= assign_id;
                        routing_state <= router_pkg::NORMAL;
                    end
                end
                router_pkg::NORMAL: begin
                    // id is fixed once joined
                end
                router_pkg::FATAL_ERROR: begin
                    routing_state <= router_pkg::FATAL_ERROR;
                end
                default: begin
                    routing_state <= router_pkg::FATAL_ERROR;
                end
            endcase
        end
    end

endmodule

/* logic/flit_decoder.sv */
`timescale 1ns/1ps

module flit_decoder (
    input  logic                       nocclk,
    input  logic                       rst_n,
    input  router_pkg::flit_t          in_flit,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  router_pkg::routing_state_e routing_state,
    input  router_pkg::node_id_t       this_node_id,
    input  logic                       expire_valid,
    output router_pkg::node_id_t       lookup_key,
    input  logic                       lookup_hit,
    input  router_pkg::node_id_t       lookup_next_hop,
    output logic                       route_write,
    output router_pkg::node_id_t       route_key,
    output router_pkg::node_id_t       route_next_hop,
    output logic                       assign_valid,
    output router_pkg::node_id_t       assign_id,
    flit_stage_if.source               stage
);

    logic                 stall;
    logic                 accept;
    logic                 accept_data;
    logic                 in_normal;
    logic                 valid_q;
    router_pkg::flit_t    flit_q;
    logic                 deliver_local_q;
    logic                 route_hit_q;
    router_pkg::node_id_t next_hop_q;

    assign stall       = (routing_state == router_pkg::FATAL_ERROR) || expire_valid;
    assign in_ready    = !stall && (!valid_q || stage.advance);
    assign accept      = in_valid && in_ready;
    assign accept_data = accept && (in_flit.kind == router_pkg::DATA);
    assign in_normal   = (routing_state == router_pkg::NORMAL);

    ////////////////////////////////////////
    // system flits become strobes

    assign route_write    = accept && (in_flit.kind == router_pkg::ROUTE_ADD);
    assign route_key      = in_flit.destination;
    assign route_next_hop = in_flit.payload[router_pkg::NODE_ID_W-1:0];
    assign assign_valid   = accept && (in_flit.kind == router_pkg::ASSIGN_ID);
    assign assign_id      = in_flit.payload[router_pkg::NODE_ID_W-1:0];

    assign lookup_key = in_flit.destination;

    ////////////////////////////////////////
    // stage 1 register

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept_data) begin
            valid_q <= 1'b1;
        end else if (stage.advance) begin
            valid_q <= 1'b0;
        end
    end

    // not joined yet, so every data flit ends up dropped
    always_ff @(posedge nocclk) begin
        if (accept_data) begin
            flit_q          <= in_flit;
            deliver_local_q <= in_normal && (in_flit.destination == this_node_id);
            route_hit_q     <= in_normal && lookup_hit;
            next_hop_q      <= lookup_next_hop;
        end
    end

    assign stage.valid         = valid_q;
    assign stage.flit          = flit_q;
    assign stage.deliver_local = deliver_local_q;
    assign stage.route_hit     = route_hit_q;
    assign stage.next_hop      = next_hop_q;

endmodule

/* logic/routing_table.sv */
`timescale 1ns/1ps

module routing_table (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::node_id_t lookup_key,
    output logic                 lookup_hit,
    output router_pkg::node_id_t lookup_next_hop,
    input  logic                 route_write,
    input  router_pkg::node_id_t route_key,
    input  router_pkg::node_id_t route_next_hop,
    input  logic                 expire_valid,
    input  router_pkg::node_id_t expire_id
);

    logic [router_pkg::NUM_NODES-1:0] entry_valid;
    router_pkg::node_id_t             entry_hop [router_pkg::NUM_NODES];

    assign lookup_hit      = entry_valid[lookup_key];
    assign lookup_next_hop = entry_hop[lookup_key];

    ////////////////////////////////////////
    // valid bits

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (expire_valid) begin
            // drop every route through the lost neighbor
            for (int i = 0; i < router_pkg::NUM_NODES; i++) begin
                if (entry_valid[i] && (entry_hop[i] == expire_id)) begin
                    entry_valid[i] <= 1'b0;
                end
            end
        end else if (route_write) begin
            entry_valid[route_key] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // next hops

    always_ff @(posedge nocclk) begin
        if (route_write && !expire_valid) begin
            entry_hop[route_key] <= route_next_hop;
        end
    end

endmodule

/* logic/neighbor_monitor.sv */
`timescale 1ns/1ps

module neighbor_monitor #(
    parameter int MAX_EXPIRE_TIME     = 500,
    parameter int MAX_NUM_OF_NEIGHBOR = 8
) (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  logic                 register_valid,
    input  router_pkg::node_id_t register_id,
    input  logic                 incoming_valid,
    input  router_pkg::node_id_t incoming_id,
    output logic                 expire_valid,
    output router_pkg::node_id_t expire_id
);

    localparam int TIMER_W = $clog2(MAX_EXPIRE_TIME + 1);
    localparam int IDX_W   = (MAX_NUM_OF_NEIGHBOR > 1) ? $clog2(MAX_NUM_OF_NEIGHBOR) : 1;

    logic [MAX_NUM_OF_NEIGHBOR-1:0] slot_used;
    router_pkg::node_id_t           slot_id    [MAX_NUM_OF_NEIGHBOR];
    logic [TIMER_W-1:0]             slot_timer [MAX_NUM_OF_NEIGHBOR];

    logic             reg_match;
    logic [IDX_W-1:0] reg_idx;
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             inc_match;
    logic [IDX_W-1:0] inc_idx;
    logic [IDX_W-1:0] exp_idx;

    // lowest index wins every search
    always_comb begin
        reg_match    = 1'b0;
        reg_idx      = '0;
        free_found   = 1'b0;
        free_idx     = '0;
        inc_match    = 1'b0;
        inc_idx      = '0;
        expire_valid = 1'b0;
        exp_idx      = '0;
        for (int i = 0; i < MAX_NUM_OF_NEIGHBOR; i++) begin
            if (!reg_match && slot_used[i] && (slot_id[i] == register_id)) begin
                reg_match = 1'b1;
                reg_idx   = IDX_W'(i);
            end
            if (!free_found && !slot_used[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (!inc_match && slot_used[i] && (slot_id[i] == incoming_id)) begin
                inc_match = 1'b1;
                inc_idx   = IDX_W'(i);
            end
            if (!expire_valid && slot_used[i] &&
                (slot_timer[i] == TIMER_W'(MAX_EXPIRE_TIME))) begin
                expire_valid = 1'b1;
                exp_idx      = IDX_W'(i);
            end
        end
        expire_id = slot_id[exp_idx];
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            slot_used <= '0;
        end else begin
            // saturate so a late expiry still fires
            for (int i = 0; i < MAX_NUM_OF_NEIGHBOR; i++) begin
                if (slot_used[i] && (slot_timer[i] != TIMER_W'(MAX_EXPIRE_TIME))) begin
                    slot_timer[i] <= slot_timer[i] + 1'b1;
                end
            end
            if (register_valid) begin
                if (reg_match) begin
                    slot_timer[reg_idx] <= '0;
                end else if (free_found) begin
                    slot_used[free_idx]  <= 1'b1;
                    slot_id[free_idx]    <= register_id;
                    slot_timer[free_idx] <= '0;
                end
            end
            if (incoming_valid && inc_match) begin
                slot_timer[inc_idx] <= '0;
            end
            if (expire_valid) begin
                slot_used[exp_idx] <= 1'b0;
            end
        end
    end

endmodule

/* logic/output_stage.sv */
`timescale 1ns/1ps

module output_stage (
    input  logic                 nocclk,
    input  logic                 rst_n,
    flit_stage_if.sink           stage,
    input  logic                 cpu_ready,
    output router_pkg::flit_t    cpu_flit,
    output logic                 cpu_valid,
    input  logic                 fwd_ready,
    output router_pkg::flit_t    fwd_flit,
    output router_pkg::node_id_t fwd_next_hop,
    output logic                 fwd_valid,
    output logic                 dropped,
    input  logic                 expire_valid
);

    logic                 valid_q;
    router_pkg::flit_t    flit_q;
    logic                 deliver_local_q;
    logic                 route_hit_q;
    router_pkg::node_id_t next_hop_q;
    logic                 leaving;

    assign cpu_valid = valid_q && deliver_local_q;
    assign fwd_valid = valid_q && !deliver_local_q && route_hit_q;
    assign dropped   = valid_q && !deliver_local_q && !route_hit_q;

    // a drop leaves right away
    assign leaving = (cpu_valid && cpu_ready) || (fwd_valid && fwd_ready) || dropped;
    assign stage.advance = !expire_valid && (!valid_q || leaving);

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (stage.advance) begin
            valid_q <= stage.valid;
        end else if (leaving) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge nocclk) begin
        if (stage.advance && stage.valid) begin
            flit_q          <= stage.flit;
            deliver_local_q <= stage.deliver_local;
            route_hit_q     <= stage.route_hit;
            next_hop_q      <= stage.next_hop;
        end
    end

    assign cpu_flit     = flit_q;
    assign fwd_flit     = flit_q;
    assign fwd_next_hop = next_hop_q;

endmodule

/* logic/router.sv */
`timescale 1ns/1ps

module router #(
    parameter bit IS_ROOT             = 1'b0,
    parameter int MAX_EXPIRE_TIME     = 500,
    parameter int MAX_NUM_OF_NEIGHBOR = 8
) (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::flit_t    transfered_flit,
    input  logic                 transfered_flit_valid,
    output logic                 transfered_flit_ready,
    input  router_pkg::node_id_t incoming_flit_node_id,
    input  logic                 incoming_flit_valid,
    output router_pkg::flit_t    noc_to_cpu_pushed_flit,
    output logic                 noc_to_cpu_pushed_flit_valid,
    input  logic                 noc_to_cpu_pushed_flit_ready,
    output router_pkg::flit_t    forwarded_flit,
    output router_pkg::node_id_t forwarded_next_hop,
    output logic                 forwarded_flit_valid,
    input  logic                 forwarded_flit_ready,
    output logic                 dropped_flit,
    output router_pkg::node_id_t this_node_id
);

    router_pkg::routing_state_e routing_state;
    router_pkg::node_id_t       lookup_key;
    logic                       lookup_hit;
    router_pkg::node_id_t       lookup_next_hop;
    logic                       route_write;
    router_pkg::node_id_t       route_key;
    router_pkg::node_id_t       route_next_hop;
    logic                       assign_valid;
    router_pkg::node_id_t       assign_id;
    logic                       expire_valid;
    router_pkg::node_id_t       expire_id;

    flit_stage_if u_stage_if ();

    ////////////////////////////////////////
    // pipeline

    flit_decoder u_flit_decoder (
        .nocclk          (nocclk),
        .rst_n           (rst_n),
        .in_flit         (transfered_flit),
        .in_valid        (transfered_flit_valid),
        .in_ready        (transfered_flit_ready),
        .routing_state   (routing_state),
        .this_node_id    (this_node_id),
        .expire_valid    (expire_valid),
        .lookup_key      (lookup_key),
        .lookup_hit      (lookup_hit),
        .lookup_next_hop (lookup_next_hop),
        .route_write     (route_write),
        .route_key       (route_key),
        .route_next_hop  (route_next_hop),
        .assign_valid    (assign_valid),
        .assign_id       (assign_id),
        .stage           (u_stage_if.source)
    );

    output_stage u_output_stage (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .stage        (u_stage_if.sink),
        .cpu_ready    (noc_to_cpu_pushed_flit_ready),
        .cpu_flit     (noc_to_cpu_pushed_flit),
        .cpu_valid    (noc_to_cpu_pushed_flit_valid),
        .fwd_ready    (forwarded_flit_ready),
        .fwd_flit     (forwarded_flit),
        .fwd_next_hop (forwarded_next_hop),
        .fwd_valid    (forwarded_flit_valid),
        .dropped      (dropped_flit),
        .expire_valid (expire_valid)
    );

    ////////////////////////////////////////
    // control

    join_controller #(
        .IS_ROOT (IS_ROOT)
    ) u_join_controller (
        .nocclk        (nocclk),
        .rst_n         (rst_n),
        .assign_valid  (assign_valid),
        .assign_id     (assign_id),
        .routing_state (routing_state),
        .this_node_id  (this_node_id)
    );

    routing_table u_routing_table (
        .nocclk          (nocclk),
        .rst_n           (rst_n),
        .lookup_key      (lookup_key),
        .lookup_hit      (lookup_hit),
        .lookup_next_hop (lookup_next_hop),
        .route_write     (route_write),
        .route_key       (route_key),
        .route_next_hop  (route_next_hop),
        .expire_valid    (expire_valid),
        .expire_id       (expire_id)
    );

    // learned next hops are the neighbors
    neighbor_monitor #(
        .MAX_EXPIRE_TIME     (MAX_EXPIRE_TIME),
        .MAX_NUM_OF_NEIGHBOR (MAX_NUM_OF_NEIGHBOR)
    ) u_neighbor_monitor (
        .nocclk         (nocclk),
        .rst_n          (rst_n),
        .register_valid (route_write),
        .register_id    (route_next_hop),
        .incoming_valid (incoming_flit_valid),
        .incoming_id    (incoming_flit_node_id),
        .expire_valid   (expire_valid),
        .expire_id      (expire_id)
    );

endmodule

/* sim/router_ref.svh */
`ifndef ROUTER_REF_SVH
`define ROUTER_REF_SVH

localparam logic [1:0] PORT_CPU  = 2'd0;
localparam logic [1:0] PORT_FWD  = 2'd1;
localparam logic [1:0] PORT_DROP = 2'd2;

typedef struct packed {
    logic [1:0]           port;
    router_pkg::flit_t    flit;
    router_pkg::node_id_t next_hop;
} expect_t;

router_pkg::routing_state_e model_state;
router_pkg::node_id_t       model_id;
logic                       model_valid [router_pkg::NUM_NODES];
router_pkg::node_id_t       model_hop   [router_pkg::NUM_NODES];

function automatic void model_reset();
    model_state = router_pkg::JOIN_WAIT;
    model_id    = router_pkg::ROOT_ID;
    for (int i = 0; i < router_pkg::NUM_NODES; i++) begin
        model_valid[i] = 1'b0;
        model_hop[i]   = '0;
    end
endfunction

// a second id is ignored once joined
function automatic void model_assign(input router_pkg::node_id_t id);
    if (model_state == router_pkg::JOIN_WAIT) begin
        model_id    = id;
        model_state = router_pkg::NORMAL;
    end
endfunction

function automatic void model_route_add(input router_pkg::node_id_t key,
                                        input router_pkg::node_id_t hop);
    model_valid[key] = 1'b1;
    model_hop[key]   = hop;
endfunction

function automatic void model_expire(input router_pkg::node_id_t hop);
    for (int i = 0; i < router_pkg::NUM_NODES; i++) begin
        if (model_valid[i] && (model_hop[i] == hop)) begin
            model_valid[i] = 1'b0;
        end
    end
endfunction

function automatic expect_t expected_result(input router_pkg::flit_t f);
    expect_t e;
    e.port     = PORT_DROP;
    e.flit     = f;
    e.next_hop = '0;
    if (model_state == router_pkg::NORMAL) begin
        if (f.destination == model_id) begin
            e.port = PORT_CPU;
        end else if (model_valid[f.destination]) begin
            e.port     = PORT_FWD;
            e.next_hop = model_hop[f.destination];
        end
    end
    return e;
endfunction

`endif

/* sim/router_tb.sv */
`timescale 1ns/1ps

module router_tb;

    `include "router_ref.svh"

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_FLITS       = 46;
    localparam int KEEP_WAIT       = 60;
    localparam int EXPIRE_WAIT     = 80;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FLITS * 100 + KEEP_WAIT + EXPIRE_WAIT;

    logic                 nocclk;
    logic                 rst_n;
    router_pkg::flit_t    transfered_flit;
    logic                 transfered_flit_valid;
    logic                 transfered_flit_ready;
    router_pkg::node_id_t incoming_flit_node_id;
    logic                 incoming_flit_valid;
    router_pkg::flit_t    noc_to_cpu_pushed_flit;
    logic                 noc_to_cpu_pushed_flit_valid;
    logic                 noc_to_cpu_pushed_flit_ready;
    router_pkg::flit_t    forwarded_flit;
    router_pkg::node_id_t forwarded_next_hop;
    logic                 forwarded_flit_valid;
    logic                 forwarded_flit_ready;
    logic                 dropped_flit;
    router_pkg::node_id_t this_node_id;

    integer      seed = 77447;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_errors_start = 0;
    logic        ready_gaps = 1'b0;
    // neighbors 2, 3 and 4 get incoming traffic
    logic [15:0] alive = 16'h001c;
    expect_t     exp_q [$];

    router #(
        .IS_ROOT             (1'b0),
        .MAX_EXPIRE_TIME     (40),
        .MAX_NUM_OF_NEIGHBOR (4)
    ) u_router (
        .nocclk                       (nocclk),
        .rst_n                        (rst_n),
        .transfered_flit              (transfered_flit),
        .transfered_flit_valid        (transfered_flit_valid),
        .transfered_flit_ready        (transfered_flit_ready),
        .incoming_flit_node_id        (incoming_flit_node_id),
        .incoming_flit_valid          (incoming_flit_valid),
        .noc_to_cpu_pushed_flit       (noc_to_cpu_pushed_flit),
        .noc_to_cpu_pushed_flit_valid (noc_to_cpu_pushed_flit_valid),
        .noc_to_cpu_pushed_flit_ready (noc_to_cpu_pushed_flit_ready),
        .forwarded_flit               (forwarded_flit),
        .forwarded_next_hop           (forwarded_next_hop),
        .forwarded_flit_valid         (forwarded_flit_valid),
        .forwarded_flit_ready         (forwarded_flit_ready),
        .dropped_flit                 (dropped_flit),
        .this_node_id                 (this_node_id)
    );

    initial begin
        nocclk = 1'b0;
        forever #10 nocclk = ~nocclk;
    end

    ////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic router_pkg::flit_t make_flit(input router_pkg::flit_kind_e kind,
                                                    input router_pkg::node_id_t dest,
                                                    input logic [15:0] payload);
        router_pkg::flit_t f;
        f.kind        = kind;
        f.destination = dest;
        f.source      = 4'd1;
        f.payload     = payload;
        return f;
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_flit(input router_pkg::flit_t f);
        transfered_flit       = f;
        transfered_flit_valid = 1'b1;
        #1;
        while (!transfered_flit_ready) begin
            @(negedge nocclk);
            #1;
        end
        @(negedge nocclk);
        transfered_flit_valid = 1'b0;
        case (f.kind)
            router_pkg::DATA:      exp_q.push_back(expected_result(f));
            router_pkg::ASSIGN_ID: model_assign(f.payload[router_pkg::NODE_ID_W-1:0]);
            router_pkg::ROUTE_ADD: begin
                model_route_add(f.destination, f.payload[router_pkg::NODE_ID_W-1:0]);
            end
            default: ;
        endcase
    endtask

    task automatic send_data(input router_pkg::node_id_t dest);
        logic [31:0] rnd;
        rnd = $random(seed);
        send_flit(make_flit(router_pkg::DATA, dest, rnd[15:0]));
    endtask

    task automatic send_route(input router_pkg::node_id_t key, input router_pkg::node_id_t hop);
        send_flit(make_flit(router_pkg::ROUTE_ADD, key, 16'(hop)));
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge nocclk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == test_errors_start) ? "passed" : "failed",
                 errors - test_errors_start);
        test_errors_start = errors;
    endtask

    ////////////////////////////////////////
    // background processes

    initial begin
        logic [31:0] r;
        noc_to_cpu_pushed_flit_ready = 1'b1;
        forwarded_flit_ready         = 1'b1;
        forever begin
            @(negedge nocclk);
            r = $random(seed);
            noc_to_cpu_pushed_flit_ready = ready_gaps ? r[0] : 1'b1;
            forwarded_flit_ready         = ready_gaps ? r[1] : 1'b1;
        end
    end

    // each live neighbor is seen once every 16 cycles
    initial begin
        incoming_flit_valid   = 1'b0;
        incoming_flit_node_id = '0;
        forever begin
            for (int i = 0; i < 16; i++) begin
                @(negedge nocclk);
                incoming_flit_valid   = alive[i];
                incoming_flit_node_id = router_pkg::node_id_t'(i);
            end
        end
    end

    initial begin
        expect_t    e;
        logic [1:0] seen;
        forever begin
            @(negedge nocclk);
            #1;
            if (rst_n && ((noc_to_cpu_pushed_flit_valid && noc_to_cpu_pushed_flit_ready) ||
                          (forwarded_flit_valid && forwarded_flit_ready) || dropped_flit)) begin
                seen = dropped_flit ? PORT_DROP :
                       (forwarded_flit_valid ? PORT_FWD : PORT_CPU);
                if (exp_q.size() == 0) begin
                    $display("unexpected output at %0t with no flit outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("output port", 32'(seen), 32'(e.port));
                    if (e.port == PORT_CPU) begin
                        check_value("noc_to_cpu_pushed_flit", 32'(noc_to_cpu_pushed_flit),
                                    32'(e.flit));
                    end else if (e.port == PORT_FWD) begin
                        check_value("forwarded_flit", 32'(forwarded_flit), 32'(e.flit));
                        check_value("forwarded_next_hop", 32'(forwarded_next_hop),
                                    32'(e.next_hop));
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge nocclk);
        $display("watchdog timeout after %0d cycles, outputs stopped arriving", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // tests

    initial begin
        router_pkg::node_id_t dest_list [5] = '{4'd5, 4'd7, 4'd8, 4'd11, 4'd13};
        logic [31:0]          rnd;
        rst_n                 = 1'b0;
        transfered_flit       = '0;
        transfered_flit_valid = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge nocclk);
        rst_n = 1'b1;

        check_value("this_node_id", 32'(this_node_id), 32'd0);
        check_value("transfered_flit_ready", 32'(transfered_flit_ready), 32'd1);
        check_value("noc_to_cpu_pushed_flit_valid", 32'(noc_to_cpu_pushed_flit_valid), 32'd0);
        check_value("forwarded_flit_valid", 32'(forwarded_flit_valid), 32'd0);
        check_value("dropped_flit", 32'(dropped_flit), 32'd0);
        send_data(4'd5);
        send_flit(make_flit(router_pkg::ASSIGN_ID, 4'd0, 16'd5));
        drain();
        check_value("this_node_id", 32'(this_node_id), 32'd5);
        finish_test("join");

        for (int i = 0; i < 6; i++) begin
            send_data(4'd5);
        end
        drain();
        finish_test("local delivery");

        send_route(4'd7, 4'd2);
        send_route(4'd8, 4'd2);
        send_route(4'd11, 4'd4);
        send_data(4'd7);
        send_data(4'd8);
        send_data(4'd11);
        send_data(4'd13);
        drain();
        finish_test("forwarding");

        ready_gaps = 1'b1;
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            send_data(dest_list[int'(rnd % 32'd5)]);
        end
        drain();
        ready_gaps = 1'b0;
        finish_test("back-pressure");

        send_route(4'd12, 4'd3);
        send_data(4'd12);
        send_data(4'd11);
        drain();
        repeat (KEEP_WAIT) @(negedge nocclk);
        send_data(4'd12);
        drain();
        // neighbor 3 goes silent
        alive[3] = 1'b0;
        repeat (EXPIRE_WAIT) @(negedge nocclk);
        model_expire(4'd3);
        send_data(4'd12);
        send_data(4'd11);
        send_data(4'd7);
        drain();
        finish_test("neighbor expiry");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+sim
logic/router_pkg.sv
logic/flit_stage_if.sv
logic/join_controller.sv
logic/flit_decoder.sv
logic/routing_table.sv
logic/neighbor_monitor.sv
logic/output_stage.sv
logic/router.sv
sim/router_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module router_tb \
    --Mdir obj_dir -o router_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
